// File: src/mrd_pkg.sv
`default_nettype none

package mrd_pkg;

	// --------------------
	// frame and banking geometry
	// --------------------

	// mod-7 banking keeps the points of one butterfly apart
	localparam int N_BANKS    = 7;
	// one lane per point of the widest butterfly
	localparam int N_LANES    = 5;
	localparam int MAX_POINTS = 1200;
	// rows per bank, rounded up
	localparam int ROWS       = (MAX_POINTS + N_BANKS - 1) / N_BANKS;

	// --------------------
	// widths with a meaning
	// --------------------

	typedef logic [$clog2(MAX_POINTS)-1:0] pt_addr_t;
	typedef logic [$clog2(ROWS)-1:0]       row_t;
	typedef logic [$clog2(N_BANKS+1)-1:0]  bank_idx_t;
	// radix 2 to 5
	typedef logic [2:0]                    radix_t;
	typedef logic signed [15:0]            sample_t;

	// bank 7 does not exist, so it tags an unused lane
	localparam bank_idx_t INVALID_BANK = bank_idx_t'(N_BANKS);

	// --------------------
	// bundles
	// --------------------

	typedef struct packed {
		sample_t re;
		sample_t im;
	} cplx_t;

	typedef struct packed {
		radix_t   radix;
		// distance between points of one butterfly
		pt_addr_t stride;
		pt_addr_t bfly_cnt;
	} stage_cfg_t;

	// point addresses of one butterfly, unused lanes zero
	typedef struct packed {
		pt_addr_t [N_LANES-1:0] addr;
		radix_t                 radix;
	} lane_addr_t;

	typedef struct packed {
		logic [N_BANKS-1:0]   en;
		row_t [N_BANKS-1:0]   row;
	} bank_rd_t;

	typedef struct packed {
		cplx_t [N_BANKS-1:0] pt;
	} bank_data_t;

	// one realigned butterfly
	typedef struct packed {
		logic                valid;
		radix_t              factor;
		cplx_t [N_LANES-1:0] pts;
	} rd_out_t;

endpackage

`default_nettype wire

// File: src/mrd_div7.sv
`timescale 1ns/100ps
`default_nettype none

module mrd_div7
(
	input  mrd_pkg::pt_addr_t  addr,
	output mrd_pkg::row_t      row,
	output mrd_pkg::bank_idx_t bank
);
	import mrd_pkg::*;

	// partial remainder, below 7 before every shift
	logic [3:0] rem;
	pt_addr_t   quo;

	// restoring long division, msb first
	always_comb
	begin
		rem = '0;
		quo = '0;
		for (int i = $bits(pt_addr_t) - 1; i >= 0; i--)
		begin
			// bring down next address bit
			rem = {rem[2:0], addr[i]};
			if (rem >= 4'd7)
			begin
				rem    = rem - 4'd7;
				quo[i] = 1'b1;
			end
		end
	end

	// quotient tops out at 171, fits a row
	assign row  = quo[$bits(row_t)-1:0];
	assign bank = rem[$bits(bank_idx_t)-1:0];

endmodule

`default_nettype wire

// File: src/mrd_addr_gen.sv
`timescale 1ns/100ps
`default_nettype none

module mrd_addr_gen
(
	input  logic                clk,
	input  logic                rst_n,
	input  logic                start,
	input  mrd_pkg::stage_cfg_t cfg,
	output mrd_pkg::lane_addr_t lanes,
	output logic                lanes_valid,
	output logic                last,
	output logic                busy
);
	import mrd_pkg::*;

	typedef enum logic {IDLE, RUN} gen_state_t;

	gen_state_t state;
	stage_cfg_t cfg_r;
	// group to group distance, radix * stride
	pt_addr_t   step;
	pt_addr_t   base;
	pt_addr_t   offset;
	// butterfly counter within the stage
	pt_addr_t   bfly;
	pt_addr_t   cur_addr [N_LANES];
	logic       accept;
	logic       is_last;
	logic       next_last;

	assign accept    = start && !busy;
	assign is_last   = (bfly == cfg_r.bfly_cnt - pt_addr_t'(1));
	// butterfly after this one closes the stage
	assign next_last = (bfly + pt_addr_t'(2) == cfg_r.bfly_cnt);

	// lane j sits j strides above base + offset
	always_comb
	begin
		cur_addr[0] = base + offset;
		for (int j = 1; j < N_LANES; j++)
			cur_addr[j] = cur_addr[j-1] + cfg_r.stride;
	end

	// --------------------
	// sequencing
	// --------------------

	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			state  <= IDLE;
			busy   <= 1'b0;
			bfly   <= '0;
			base   <= '0;
			offset <= '0;
		end
		else if (accept)
		begin
			state  <= RUN;
			// single butterfly stage never blocks a start
			busy   <= (cfg.bfly_cnt > pt_addr_t'(1));
			bfly   <= '0;
			base   <= '0;
			offset <= '0;
		end
		else if (state == RUN)
		begin
			bfly <= bfly + pt_addr_t'(1);
			// drop busy one early so the next stage starts with no gap
			if (next_last)
				busy <= 1'b0;
			if (is_last)
				state <= IDLE;
			// offset wraps at stride, base jumps a whole group
			if (offset == cfg_r.stride - pt_addr_t'(1))
			begin
				offset <= '0;
				base   <= base + step;
			end
			else
				offset <= offset + pt_addr_t'(1);
		end
	end

	always_ff @(posedge clk)
	begin
		if (accept)
		begin
			cfg_r <= cfg;
			step  <= pt_addr_t'(cfg.radix) * cfg.stride;
		end
	end

	// --------------------
	// butterfly issue
	// --------------------

	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			lanes_valid <= 1'b0;
			last        <= 1'b0;
		end
		else
		begin
			lanes_valid <= (state == RUN);
			last        <= (state == RUN) && is_last;
		end
	end

	// lanes at or above radix go out as zero
	always_ff @(posedge clk)
	begin
		for (int j = 0; j < N_LANES; j++)
			lanes.addr[j] <= (radix_t'(j) < cfg_r.radix) ? cur_addr[j] : '0;
		lanes.radix <= cfg_r.radix;
	end

endmodule

`default_nettype wire

// File: src/mrd_bank_mem.sv
`timescale 1ns/100ps
`default_nettype none

module mrd_bank_mem
(
	input  logic                clk,
	input  logic                wr_en,
	input  mrd_pkg::pt_addr_t   wr_addr,
	input  mrd_pkg::cplx_t      wr_data,
	input  mrd_pkg::bank_rd_t   rd_req,
	output mrd_pkg::bank_data_t rd_data
);
	import mrd_pkg::*;

	row_t      wr_row;
	bank_idx_t wr_bank;
	// registered read port per bank
	cplx_t     rd_q [N_BANKS];

	// write address splits into bank and row
	mrd_div7 u_wr_div7
	(
		.addr (wr_addr),
		.row  (wr_row),
		.bank (wr_bank)
	);

	// --------------------
	// banks
	// --------------------

	for (genvar b = 0; b < N_BANKS; b++)
	begin : g_bank
		cplx_t mem [ROWS];

		always_ff @(posedge clk)
		begin
			if (wr_en && wr_bank == bank_idx_t'(b))
				mem[wr_row] <= wr_data;
			// idle bank holds its last word
			if (rd_req.en[b])
				rd_q[b] <= mem[rd_req.row[b]];
		end
	end

	always_comb
	begin
		for (int b = 0; b < N_BANKS; b++)
			rd_data.pt[b] = rd_q[b];
	end

endmodule

`default_nettype wire

// File: src/mrd_rd_ctrl.sv
`timescale 1ns/100ps
`default_nettype none

module mrd_rd_ctrl
(
	input  logic                clk,
	input  logic                rst_n,
	input  logic                start,
	input  mrd_pkg::stage_cfg_t cfg,
	output mrd_pkg::bank_rd_t   rd_req,
	input  mrd_pkg::bank_data_t rd_data,
	output mrd_pkg::rd_out_t    rd_out,
	output logic                rd_end,
	output logic                busy
);
	import mrd_pkg::*;

	lane_addr_t          lanes;
	logic                lanes_valid;
	logic                lanes_last;
	row_t                div_row  [N_LANES];
	bank_idx_t           div_bank [N_LANES];

	// stage 1, per lane bank and row
	bank_idx_t           bank_s1 [N_LANES];
	row_t                row_s1  [N_LANES];
	radix_t              radix_s1;
	logic                valid_s1;
	logic                last_s1;

	// stage 2, bank requests
	logic [N_BANKS-1:0]  hit;
	row_t [N_BANKS-1:0]  hit_row;
	logic [N_BANKS-1:0]  req_en;
	row_t [N_BANKS-1:0]  req_row;
	bank_idx_t           bank_s2 [N_LANES];
	radix_t              radix_s2;
	logic                valid_s2;
	logic                last_s2;

	// stage 3, lines up with the memory read
	bank_idx_t           bank_s3 [N_LANES];
	radix_t              radix_s3;
	logic                valid_s3;
	logic                last_s3;
	cplx_t [N_LANES-1:0] gather;

	mrd_addr_gen u_addr_gen
	(
		.clk         (clk),
		.rst_n       (rst_n),
		.start       (start),
		.cfg         (cfg),
		.lanes       (lanes),
		.lanes_valid (lanes_valid),
		.last        (lanes_last),
		.busy        (busy)
	);

	for (genvar j = 0; j < N_LANES; j++)
	begin : g_lane_div
		mrd_div7 u_div7
		(
			.addr (lanes.addr[j]),
			.row  (div_row[j]),
			.bank (div_bank[j])
		);
	end

	// --------------------
	// stage 1
	// --------------------

	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			bank_s1  <= '{default: INVALID_BANK};
			valid_s1 <= 1'b0;
			last_s1  <= 1'b0;
		end
		else
		begin
			// idle cycles and lanes past radix read nothing
			for (int j = 0; j < N_LANES; j++)
				if (lanes_valid && radix_t'(j) < lanes.radix)
					bank_s1[j] <= div_bank[j];
				else
					bank_s1[j] <= INVALID_BANK;
			valid_s1 <= lanes_valid;
			last_s1  <= lanes_last;
		end
	end

	always_ff @(posedge clk)
	begin
		for (int j = 0; j < N_LANES; j++)
			row_s1[j] <= div_row[j];
		radix_s1 <= lanes.radix;
	end

	// --------------------
	// stage 2
	// --------------------

	// each bank looks for the lane that picked it
	always_comb
	begin
		hit     = '0;
		hit_row = '0;
		for (int b = 0; b < N_BANKS; b++)
			for (int j = N_LANES - 1; j >= 0; j--)
				if (bank_s1[j] == bank_idx_t'(b))
				begin
					hit[b]     = 1'b1;
					hit_row[b] = row_s1[j];
				end
	end

	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			req_en   <= '0;
			bank_s2  <= '{default: INVALID_BANK};
			valid_s2 <= 1'b0;
			last_s2  <= 1'b0;
		end
		else
		begin
			req_en   <= hit;
			bank_s2  <= bank_s1;
			valid_s2 <= valid_s1;
			last_s2  <= last_s1;
		end
	end

	always_ff @(posedge clk)
	begin
		req_row  <= hit_row;
		radix_s2 <= radix_s1;
	end

	assign rd_req = '{en: req_en, row: req_row};

	// --------------------
	// stage 3 and output
	// --------------------

	// lane tags ride along while the banks read
	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			bank_s3  <= '{default: INVALID_BANK};
			valid_s3 <= 1'b0;
			last_s3  <= 1'b0;
		end
		else
		begin
			bank_s3  <= bank_s2;
			valid_s3 <= valid_s2;
			last_s3  <= last_s2;
		end
	end

	always_ff @(posedge clk)
	begin
		radix_s3 <= radix_s2;
	end

	// realign bank words into lane order
	always_comb
	begin
		for (int j = 0; j < N_LANES; j++)
			if (bank_s3[j] == INVALID_BANK)
				gather[j] = '0;
			else
				gather[j] = rd_data.pt[bank_s3[j]];
	end

	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			rd_out <= '0;
			rd_end <= 1'b0;
		end
		else
		begin
			rd_out.valid  <= valid_s3;
			rd_out.factor <= valid_s3 ? radix_s3 : '0;
			rd_out.pts    <= gather;
			// stage end on last butterfly only
			rd_end        <= valid_s3 && last_s3;
		end
	end

endmodule

`default_nettype wire

// File: src/mrd_top.sv
`timescale 1ns/100ps
`default_nettype none

module mrd_top
(
	input  logic                clk,
	input  logic                rst_n,
	input  logic                start,
	input  mrd_pkg::stage_cfg_t cfg,
	input  logic                wr_en,
	input  mrd_pkg::pt_addr_t   wr_addr,
	input  mrd_pkg::cplx_t      wr_data,
	output mrd_pkg::rd_out_t    rd_out,
	output logic                rd_end,
	output logic                busy
);
	import mrd_pkg::*;

	// bank request and returned words
	bank_rd_t   rd_req;
	bank_data_t rd_data;

	mrd_rd_ctrl u_rd_ctrl
	(
		.clk     (clk),
		.rst_n   (rst_n),
		.start   (start),
		.cfg     (cfg),
		.rd_req  (rd_req),
		.rd_data (rd_data),
		.rd_out  (rd_out),
		.rd_end  (rd_end),
		.busy    (busy)
	);

	mrd_bank_mem u_bank_mem
	(
		.clk     (clk),
		.wr_en   (wr_en),
		.wr_addr (wr_addr),
		.wr_data (wr_data),
		.rd_req  (rd_req),
		.rd_data (rd_data)
	);

endmodule

`default_nettype wire

// File: verification/mrd_tb.sv
`timescale 1ns/100ps
`default_nettype none

module mrd_tb;
	import mrd_pkg::*;

	localparam int CLK_PERIOD = 4;
	localparam int N_STAGES   = 12;
	localparam int N_UPDATES  = 300;
	// reset, idle gaps and pipeline drain on top of the writes and butterflies
	localparam int MARGIN     = 2000;

	typedef logic [191:0] chk_t;

	logic        clk;
	logic        rst_n;
	logic        start;
	stage_cfg_t  cfg;
	logic        wr_en;
	pt_addr_t    wr_addr;
	cplx_t       wr_data;
	rd_out_t     rd_out;
	logic        rd_end;
	logic        busy;

	logic [31:0] rng_state = 32'd11;
	int          cyc = 0;
	int          n_checks = 0;
	int          n_errors = 0;
	int          n_ends = 0;
	int          limit_cycles = 0;
	logic        started;

	// frame model and the stage list
	cplx_t       frame [MAX_POINTS];
	stage_cfg_t  stages [$];
	// expected butterflies, oldest first
	int          exp_cyc [$];
	rd_out_t     exp_out [$];
	logic        exp_end [$];

	mrd_top u_dut
	(
		.clk     (clk),
		.rst_n   (rst_n),
		.start   (start),
		.cfg     (cfg),
		.wr_en   (wr_en),
		.wr_addr (wr_addr),
		.wr_data (wr_data),
		.rd_out  (rd_out),
		.rd_end  (rd_end),
		.busy    (busy)
	);

	initial
		clk = 1'b0;

	always #(CLK_PERIOD / 2) clk = ~clk;

	// edge counter, the time base for expected output cycles
	always @(posedge clk)
		cyc <= cyc + 1;

	// --------------------
	// helpers
	// --------------------

	function automatic logic [31:0] rand_next();
		logic [31:0] x;
		x = rng_state;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		rng_state = x;
		return x;
	endfunction

	task automatic check_val(input string name, input chk_t got, input chk_t exp);
		n_checks++;
		if (got !== exp)
		begin
			n_errors++;
			$display("Mismatch %s: got %h expected %h at cycle %0d",
				name, got, exp, cyc);
		end
	endtask

	// radix 2..5, frame 60, 120 or 1200, some stages split into groups
	function automatic stage_cfg_t pick_stage(input int idx);
		int sizes [3] = '{60, 120, 1200};
		int divs  [4] = '{1, 2, 3, 5};
		stage_cfg_t c;
		int n;
		int r;
		int d;
		n = sizes[int'(rand_next() % 32'd3)];
		r = (idx < 4) ? idx + 2 : 2 + int'(rand_next() % 32'd4);
		d = divs[int'(rand_next() % 32'd4)];
		if ((n / r) % d != 0)
			d = 1;
		c.radix    = radix_t'(r);
		c.stride   = pt_addr_t'(n / r / d);
		c.bfly_cnt = pt_addr_t'(n / r);
		return c;
	endfunction

	// butterfly k: group k/stride, offset k%stride, lanes a stride apart
	task automatic push_expected(input stage_cfg_t c, input int e0);
		rd_out_t e;
		int base;
		int k;
		int j;
		int r;
		int s;
		int cnt;
		r   = int'(c.radix);
		s   = int'(c.stride);
		cnt = int'(c.bfly_cnt);
		for (k = 0; k < cnt; k++)
		begin
			base     = (k / s) * r * s + k % s;
			e        = '0;
			e.valid  = 1'b1;
			e.factor = c.radix;
			for (j = 0; j < r; j++)
				e.pts[j] = frame[base + j * s];
			exp_cyc.push_back(e0 + 5 + k);
			exp_out.push_back(e);
			exp_end.push_back(k == cnt - 1);
		end
	endtask

	task automatic write_point(input int a, input cplx_t data);
		wr_en   = 1'b1;
		wr_addr = pt_addr_t'(a);
		wr_data = data;
		@(posedge clk);
		#1;
		wr_en = 1'b0;
	endtask

	// start on the first cycle busy is low
	task automatic run_stage(input stage_cfg_t c);
		stage_cfg_t junk;
		int n;
		junk = '{radix: radix_t'(2), stride: pt_addr_t'(1), bfly_cnt: pt_addr_t'(3)};
		n    = 0;
		while (busy)
		begin
			// stray start while busy, must not be taken
			start = (n == 2);
			cfg   = junk;
			@(posedge clk);
			#1;
			n++;
		end
		started = 1'b1;
		start   = 1'b1;
		cfg     = c;
		@(posedge clk);
		#1;
		start = 1'b0;
		push_expected(c, cyc);
	endtask

	task automatic wait_drain();
		while (exp_cyc.size() > 0)
		begin
			@(posedge clk);
			#1;
		end
	endtask

	// --------------------
	// monitor
	// --------------------

	// outputs settle after the rising edge, so sample on the falling one
	always @(negedge clk)
	begin
		if (rst_n)
		begin
			// idle after reset
			if (!started)
			begin
				check_val("rd_out", chk_t'(rd_out), '0);
				check_val("busy", chk_t'(busy), '0);
			end
			if (rd_end)
				n_ends++;
			if (rd_out.valid)
			begin
				if (exp_cyc.size() == 0)
				begin
					n_errors++;
					$display("Error: valid output at cycle %0d with no butterfly expected", cyc);
				end
				else
				begin
					check_val("rd_out cycle", chk_t'(cyc), chk_t'(exp_cyc.pop_front()));
					check_val("rd_out", chk_t'(rd_out), chk_t'(exp_out.pop_front()));
					check_val("rd_end", chk_t'(rd_end), chk_t'(exp_end.pop_front()));
				end
			end
			else
				check_val("rd_end", chk_t'(rd_end), '0);
		end
	end

	// --------------------
	// stimulus
	// --------------------

	initial
	begin
		int s;
		int a;
		int total;
		rst_n   = 1'b0;
		start   = 1'b0;
		cfg     = '0;
		wr_en   = 1'b0;
		wr_addr = '0;
		wr_data = '0;
		started = 1'b0;
		total   = 0;
		for (s = 0; s < N_STAGES; s++)
		begin
			stages.push_back(pick_stage(s));
			total += int'(stages[s].bfly_cnt);
		end
		// last stage runs twice
		total += int'(stages[N_STAGES-1].bfly_cnt);
		limit_cycles = 8 + MAX_POINTS + N_UPDATES + total + MARGIN;

		repeat (8) @(posedge clk);
		#1;
		rst_n = 1'b1;

		// whole frame loaded before any read
		for (a = 0; a < MAX_POINTS; a++)
		begin
			frame[a] = cplx_t'(rand_next());
			write_point(a, frame[a]);
		end
		repeat (4) @(posedge clk);
		#1;

		// back to back stages
		for (s = 0; s < N_STAGES; s++)
			run_stage(stages[s]);
		wait_drain();

		// overwrite part of the frame, then read it again
		for (s = 0; s < N_UPDATES; s++)
		begin
			a        = int'(rand_next() % 32'(MAX_POINTS));
			frame[a] = cplx_t'(rand_next());
			write_point(a, frame[a]);
		end
		run_stage(stages[N_STAGES-1]);
		wait_drain();
		repeat (8) @(posedge clk);
		#1;

		check_val("rd_end count", chk_t'(n_ends), chk_t'(N_STAGES + 1));
		check_val("busy", chk_t'(busy), '0);
		$display("checks %0d errors %0d", n_checks, n_errors);
		if (n_errors == 0)
			$display("All checks passed");
		else
			$display("Checks failed");
		$finish;
	end

	// watchdog
	initial
	begin
		wait (limit_cycles > 0);
		repeat (limit_cycles) @(posedge clk);
		$display("Timeout: run did not finish within %0d cycles", limit_cycles);
		$display("Checks failed");
		$finish;
	end

endmodule

`default_nettype wire

// File: project.f
src/mrd_pkg.sv
src/mrd_div7.sv
src/mrd_addr_gen.sv
src/mrd_bank_mem.sv
src/mrd_rd_ctrl.sv
src/mrd_top.sv
verification/mrd_tb.sv

// File: run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal --top-module mrd_tb \
	-f project.f -Mdir obj_dir -o mrd_sim

./obj_dir/mrd_sim > sim.log
cat sim.log

if grep -q "Checks failed" sim.log; then
	echo "simulation FAILED"
	exit 1
fi
echo "simulation passed"
